// File: verilog/mem_wr_settings.svh
`ifndef MEM_WR_SETTINGS_SVH
`define MEM_WR_SETTINGS_SVH

// Address width, the memory holds 2**MEM_ADDR_WID words
`define MEM_ADDR_WID 4

`define MEM_DATA_WID 32

// Entries in the host command FIFO
`define CMD_QUEUE_DEPTH 4

// Cycles from an accepted req to ack
`define MEM_WR_LATENCY 3

`endif

// File: verilog/mem_wr_pkg.sv
`include "mem_wr_settings.svh"

package mem_wr_pkg;

    // Memory bus fields
    typedef logic [`MEM_ADDR_WID-1:0] addr_t;
    typedef logic [`MEM_DATA_WID-1:0] data_t;

    // Host command kinds
    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_CLEAR = 1'b1
    } cmd_kind_e;

    // Command FIFO payload, kind in the top bit
    typedef struct packed {
        cmd_kind_e kind;
        addr_t     addr;
        data_t     data;
    } wr_cmd_t;

endpackage : mem_wr_pkg

// File: verilog/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    // Write controller FSM
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        WAIT_RDY = 2'd1, // en high, waiting to issue req
        WAIT_ACK = 2'd2, // req issued, waiting for ack
        CLEAR    = 2'd3  // one-cycle rst pulse
    } ctrl_state_e;

    // Memory peripheral FSM
    typedef enum logic {
        READY = 1'b0,
        BUSY  = 1'b1
    } periph_state_e;

endpackage : mem_ctrl_pkg

// File: verilog/wr_cmd_queue.sv
`timescale 1ns/1ps
`include "mem_wr_settings.svh"

module wr_cmd_queue (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  mem_wr_pkg::wr_cmd_t push_cmd,
    output logic                full,
    input  logic                pop,
    output mem_wr_pkg::wr_cmd_t head,
    output logic                empty
);

    localparam int DEPTH   = `CMD_QUEUE_DEPTH;
    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    mem_wr_pkg::wr_cmd_t entries [DEPTH];

    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               do_push;
    logic               do_pop;

    // Circular pointer advance, depth need not be a power of two
    function automatic logic [PTR_WID-1:0] next_ptr(input logic [PTR_WID-1:0] ptr);
        if (ptr == PTR_WID'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == CNT_WID'(DEPTH));
    assign empty = (count == '0);
    assign head  = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_cmd;
        end
    end

    // Host must hold off while full
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset) push |-> !full
    ) else $error("Command pushed while queue full");

    // Controller only pops a valid head
    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    ) else $error("Command popped while queue empty");

endmodule : wr_cmd_queue

// File: verilog/mem_wr_controller.sv
`timescale 1ns/1ps

module mem_wr_controller (
    input  logic                clk,
    input  logic                reset,
    input  logic                empty,
    input  mem_wr_pkg::wr_cmd_t head,
    output logic                pop,
    input  logic                rdy,
    input  logic                ack,
    output logic                en,
    output logic                req,
    output logic                rst,
    output mem_wr_pkg::addr_t   addr,
    output mem_wr_pkg::data_t   data,
    output logic                idle
);

    mem_ctrl_pkg::ctrl_state_e state;
    mem_ctrl_pkg::ctrl_state_e state_next;

    mem_wr_pkg::addr_t addr_q;
    mem_wr_pkg::data_t data_q;

    always_comb begin
        state_next = state;
        case (state)
            mem_ctrl_pkg::IDLE: begin
                if (!empty) begin
                    if (head.kind == mem_wr_pkg::CMD_CLEAR) begin
                        state_next = mem_ctrl_pkg::CLEAR;
                    end else begin
                        state_next = mem_ctrl_pkg::WAIT_RDY;
                    end
                end
            end
            mem_ctrl_pkg::WAIT_RDY: begin
                if (rdy) begin
                    state_next = mem_ctrl_pkg::WAIT_ACK; // req goes out this cycle
                end
            end
            mem_ctrl_pkg::WAIT_ACK: begin
                if (ack) begin
                    state_next = mem_ctrl_pkg::IDLE;
                end
            end
            mem_ctrl_pkg::CLEAR: begin
                state_next = mem_ctrl_pkg::IDLE;
            end
            default: begin
                state_next = mem_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mem_ctrl_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Latch the head as it leaves the queue
    always_ff @(posedge clk) begin
        if (pop) begin
            addr_q <= head.addr;
            data_q <= head.data;
        end
    end

    assign pop  = (state == mem_ctrl_pkg::IDLE) && !empty;
    assign idle = (state == mem_ctrl_pkg::IDLE) && empty;

    assign en   = (state == mem_ctrl_pkg::WAIT_RDY) || (state == mem_ctrl_pkg::WAIT_ACK);
    assign req  = (state == mem_ctrl_pkg::WAIT_RDY) && rdy; // Single cycle, rdy drops after
    assign rst  = (state == mem_ctrl_pkg::CLEAR);
    assign addr = addr_q;
    assign data = data_q;

    req_within_en: assert property (
        @(posedge clk) disable iff (reset) req |-> en
    ) else $error("req raised without en");

endmodule : mem_wr_controller

// File: verilog/mem_wr_peripheral.sv
`timescale 1ns/1ps
`include "mem_wr_settings.svh"

module mem_wr_peripheral (
    input  logic              clk,
    input  logic              reset,
    input  logic              rst,
    input  logic              en,
    input  logic              req,
    input  mem_wr_pkg::addr_t addr,
    input  mem_wr_pkg::data_t data,
    output logic              rdy,
    output logic              ack,
    input  mem_wr_pkg::addr_t rd_addr,
    output mem_wr_pkg::data_t rd_data
);

    localparam int LAT     = `MEM_WR_LATENCY;
    localparam int CNT_WID = $clog2(LAT + 1);
    localparam int WORDS   = 1 << `MEM_ADDR_WID;

    mem_ctrl_pkg::periph_state_e state;

    logic [CNT_WID-1:0] busy_cnt;
    logic               accept;

    mem_wr_pkg::data_t mem [WORDS];

    assign rdy     = (state == mem_ctrl_pkg::READY);
    assign accept  = en && req && rdy;
    assign rd_data = mem[rd_addr]; // Combinational read port

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= mem_ctrl_pkg::READY;
            busy_cnt <= '0;
            ack      <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                mem_ctrl_pkg::READY: begin
                    if (accept) begin
                        state    <= mem_ctrl_pkg::BUSY;
                        busy_cnt <= '0;
                    end
                end
                mem_ctrl_pkg::BUSY: begin
                    if (busy_cnt == CNT_WID'(LAT - 1)) begin
                        state    <= mem_ctrl_pkg::READY;
                        busy_cnt <= '0;
                        ack      <= 1'b1; // Lands with rdy back high
                    end else begin
                        busy_cnt <= busy_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= mem_ctrl_pkg::READY;
                end
            endcase
        end
    end

    // Memory comes up zeroed and rst wipes it in one cycle
    always_ff @(posedge clk) begin
        if (reset || rst) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (accept) begin
            mem[addr] <= data;
        end
    end

    req_only_when_rdy: assert property (
        @(posedge clk) disable iff (reset) req |-> rdy
    ) else $error("req while peripheral busy");

    ack_single_pulse: assert property (
        @(posedge clk) disable iff (reset) ack |=> !ack
    ) else $error("ack held longer than one cycle");

endmodule : mem_wr_peripheral

// File: verilog/mem_wr_top.sv
`timescale 1ns/1ps

module mem_wr_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_push,
    input  mem_wr_pkg::cmd_kind_e cmd_kind,
    input  mem_wr_pkg::addr_t     cmd_addr,
    input  mem_wr_pkg::data_t     cmd_data,
    output logic                  cmd_full,
    output logic                  idle,
    input  mem_wr_pkg::addr_t     rd_addr,
    output mem_wr_pkg::data_t     rd_data
);

    // Queue to controller
    logic                empty;
    logic                pop;
    mem_wr_pkg::wr_cmd_t head;

    // Memory write handshake
    logic              rst;
    logic              rdy;
    logic              en;
    logic              req;
    mem_wr_pkg::addr_t addr;
    mem_wr_pkg::data_t data;
    logic              ack;

    wr_cmd_queue u_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (cmd_push),
        .push_cmd ({cmd_kind, cmd_addr, cmd_data}),
        .full     (cmd_full),
        .pop      (pop),
        .head     (head),
        .empty    (empty)
    );

    mem_wr_controller u_controller (
        .clk   (clk),
        .reset (reset),
        .empty (empty),
        .head  (head),
        .pop   (pop),
        .rdy   (rdy),
        .ack   (ack),
        .en    (en),
        .req   (req),
        .rst   (rst),
        .addr  (addr),
        .data  (data),
        .idle  (idle)
    );

    mem_wr_peripheral u_peripheral (
        .clk     (clk),
        .reset   (reset),
        .rst     (rst),
        .en      (en),
        .req     (req),
        .addr    (addr),
        .data    (data),
        .rdy     (rdy),
        .ack     (ack),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule : mem_wr_top

// File: dv/tb_mem_wr_table.svh
`ifndef TB_MEM_WR_TABLE_SVH
`define TB_MEM_WR_TABLE_SVH

// Columns are name, operation, address, data, expected read value
task automatic load_table;
    add_entry("reset_zero",    OP_READ_ALL,  4'h0, 32'h0000_0000, 32'h0000_0000);

    // Single write with readback
    add_entry("single_wr",     OP_WRITE,     4'h5, 32'hdead_beef, 32'h0000_0000);
    add_entry("single_wait",   OP_WAIT_IDLE, 4'h0, 32'h0000_0000, 32'h0000_0000);
    add_entry("single_rd",     OP_READ,      4'h5, 32'h0000_0000, 32'hdead_beef);
    add_entry("single_others", OP_READ_ALL,  4'h0, 32'h0000_0000, 32'h0000_0000);

    // Eight writes back to back, twice the FIFO depth
    add_entry("b2b_wr0",       OP_WRITE,     4'h0, 32'h1111_0000, 32'h0000_0000);
    add_entry("b2b_wr1",       OP_WRITE,     4'h1, 32'h2222_0001, 32'h0000_0000);
    add_entry("b2b_wr2",       OP_WRITE,     4'h2, 32'h3333_0002, 32'h0000_0000);
    add_entry("b2b_wr3",       OP_WRITE,     4'h3, 32'h4444_0003, 32'h0000_0000);
    add_entry("b2b_wr4",       OP_WRITE,     4'h4, 32'h5555_0004, 32'h0000_0000);
    add_entry("b2b_wr5",       OP_WRITE,     4'h6, 32'h6666_0006, 32'h0000_0000);
    add_entry("b2b_wr6",       OP_WRITE,     4'h7, 32'h7777_0007, 32'h0000_0000);
    add_entry("b2b_wr7",       OP_WRITE,     4'hf, 32'h8888_000f, 32'h0000_0000);
    add_entry("b2b_wait",      OP_WAIT_IDLE, 4'h0, 32'h0000_0000, 32'h0000_0000);
    add_entry("b2b_rd0",       OP_READ,      4'h0, 32'h0000_0000, 32'h1111_0000);
    add_entry("b2b_rd7",       OP_READ,      4'hf, 32'h0000_0000, 32'h8888_000f);
    add_entry("b2b_all",       OP_READ_ALL,  4'h0, 32'h0000_0000, 32'h0000_0000);

    // Same address written three times
    add_entry("rep_wr0",       OP_WRITE,     4'h9, 32'h0000_00a1, 32'h0000_0000);
    add_entry("rep_wr1",       OP_WRITE,     4'h9, 32'h0000_00b2, 32'h0000_0000);
    add_entry("rep_wr2",       OP_WRITE,     4'h9, 32'h0000_00c3, 32'h0000_0000);
    add_entry("rep_wait",      OP_WAIT_IDLE, 4'h0, 32'h0000_0000, 32'h0000_0000);
    add_entry("rep_rd",        OP_READ,      4'h9, 32'h0000_0000, 32'h0000_00c3);

    // Clear between writes, no wait around it
    add_entry("clr_pre_wr2",   OP_WRITE,     4'h2, 32'hcafe_0002, 32'h0000_0000);
    add_entry("clr_pre_wr3",   OP_WRITE,     4'h3, 32'hcafe_0003, 32'h0000_0000);
    add_entry("clr_cmd",       OP_CLEAR,     4'h0, 32'h0000_0000, 32'h0000_0000);
    add_entry("clr_post_wr4",  OP_WRITE,     4'h4, 32'hbeef_0004, 32'h0000_0000);
    add_entry("clr_post_wr3",  OP_WRITE,     4'h3, 32'hbeef_0003, 32'h0000_0000);
    add_entry("clr_wait",      OP_WAIT_IDLE, 4'h0, 32'h0000_0000, 32'h0000_0000);
    add_entry("clr_rd2",       OP_READ,      4'h2, 32'h0000_0000, 32'h0000_0000);
    add_entry("clr_rd3",       OP_READ,      4'h3, 32'h0000_0000, 32'hbeef_0003);
    add_entry("clr_rd4",       OP_READ,      4'h4, 32'h0000_0000, 32'hbeef_0004);
    add_entry("clr_rd5",       OP_READ,      4'h5, 32'h0000_0000, 32'h0000_0000);
    add_entry("clr_rd9",       OP_READ,      4'h9, 32'h0000_0000, 32'h0000_0000);
    add_entry("clr_all",       OP_READ_ALL,  4'h0, 32'h0000_0000, 32'h0000_0000);

    // Random section, data column is the write count
    add_entry("rand_wr",       OP_RAND,      4'h0, 32'd20,        32'h0000_0000);
    add_entry("rand_wait",     OP_WAIT_IDLE, 4'h0, 32'h0000_0000, 32'h0000_0000);
    add_entry("rand_all",      OP_READ_ALL,  4'h0, 32'h0000_0000, 32'h0000_0000);
endtask

`endif

// File: dv/tb_mem_wr.sv
`timescale 1ns/1ps
`include "mem_wr_settings.svh"

module tb_mem_wr;

    localparam int OP_WRITE     = 0;
    localparam int OP_CLEAR     = 1;
    localparam int OP_WAIT_IDLE = 2;
    localparam int OP_READ      = 3; // One address against the table value
    localparam int OP_READ_ALL  = 4; // Every address against the model
    localparam int OP_RAND      = 5;

    localparam int WORDS = 1 << `MEM_ADDR_WID;

    logic                  clk;
    logic                  reset;
    logic                  cmd_push;
    mem_wr_pkg::cmd_kind_e cmd_kind;
    mem_wr_pkg::addr_t     cmd_addr;
    mem_wr_pkg::data_t     cmd_data;
    logic                  cmd_full;
    logic                  idle;
    mem_wr_pkg::addr_t     rd_addr;
    mem_wr_pkg::data_t     rd_data;

    string             t_name [$];
    int                t_op   [$];
    mem_wr_pkg::addr_t t_addr [$];
    mem_wr_pkg::data_t t_data [$];
    mem_wr_pkg::data_t t_exp  [$];

    mem_wr_pkg::data_t model [WORDS]; // Reference memory

    integer seed        = 46;
    int     errors      = 0;
    int     checks      = 0;
    int     cycle_limit = 0;
    int     cycles      = 0;
    logic   full_seen   = 1'b0;

    mem_wr_top dut (
        .clk      (clk),
        .reset    (reset),
        .cmd_push (cmd_push),
        .cmd_kind (cmd_kind),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .cmd_full (cmd_full),
        .idle     (idle),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    always #4 clk = ~clk;

    `include "tb_mem_wr_table.svh"

    task automatic add_entry(input string name, input int op, input mem_wr_pkg::addr_t a,
                             input mem_wr_pkg::data_t d, input mem_wr_pkg::data_t e);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(a);
        t_data.push_back(d);
        t_exp.push_back(e);
    endtask

    task automatic check_value(input string name, input mem_wr_pkg::data_t expected,
                               input mem_wr_pkg::data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic send_cmd(input mem_wr_pkg::cmd_kind_e kind, input mem_wr_pkg::addr_t a,
                            input mem_wr_pkg::data_t d);
        while (cmd_full) begin
            full_seen = 1'b1;
            @(posedge clk);
            #1;
        end
        cmd_push = 1'b1;
        cmd_kind = kind;
        cmd_addr = a;
        cmd_data = d;
        @(posedge clk);
        #1;
        cmd_push = 1'b0;
    endtask

    task automatic wait_idle;
        while (!idle) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_word(input mem_wr_pkg::addr_t a, output mem_wr_pkg::data_t d);
        rd_addr = a;
        #2;
        d = rd_data;
        @(posedge clk);
        #1;
    endtask

    task automatic run_entry(input int i);
        mem_wr_pkg::data_t word;
        mem_wr_pkg::addr_t a;
        mem_wr_pkg::data_t d;
        int                j;
        case (t_op[i])
            OP_WRITE: begin
                model[t_addr[i]] = t_data[i];
                send_cmd(mem_wr_pkg::CMD_WRITE, t_addr[i], t_data[i]);
            end
            OP_CLEAR: begin
                for (j = 0; j < WORDS; j++) begin
                    model[j] = '0;
                end
                send_cmd(mem_wr_pkg::CMD_CLEAR, '0, '0);
            end
            OP_WAIT_IDLE: begin
                wait_idle();
            end
            OP_READ: begin
                read_word(t_addr[i], word);
                check_value(t_name[i], t_exp[i], word);
            end
            OP_READ_ALL: begin
                for (j = 0; j < WORDS; j++) begin
                    read_word(mem_wr_pkg::addr_t'(j), word);
                    check_value($sformatf("%s[%0d]", t_name[i], j), model[j], word);
                end
            end
            OP_RAND: begin
                for (j = 0; j < int'(t_data[i]); j++) begin
                    a = mem_wr_pkg::addr_t'($random(seed));
                    d = $random(seed);
                    model[a] = d;
                    send_cmd(mem_wr_pkg::CMD_WRITE, a, d);
                end
            end
            default: begin
                errors++;
                $display("Table entry %0d has an unknown operation %0d", i, t_op[i]);
            end
        endcase
    endtask

    initial begin
        int i;
        int units;
        clk      = 1'b0;
        reset    = 1'b1;
        cmd_push = 1'b0;
        cmd_kind = mem_wr_pkg::CMD_WRITE;
        cmd_addr = '0;
        cmd_data = '0;
        rd_addr  = '0;
        for (i = 0; i < WORDS; i++) begin
            model[i] = '0; // Memory comes out of reset zeroed
        end
        load_table();
        units = 0;
        for (i = 0; i < t_op.size(); i++) begin
            units += (t_op[i] == OP_RAND) ? int'(t_data[i]) : 1;
        end
        cycle_limit = units * (`MEM_WR_LATENCY + 8) + 200;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("reset_idle", 1, mem_wr_pkg::data_t'(idle));
        check_value("reset_full", 0, mem_wr_pkg::data_t'(cmd_full));
        for (i = 0; i < t_op.size(); i++) begin
            run_entry(i);
        end
        check_value("full_seen", 1, mem_wr_pkg::data_t'(full_seen)); // Back-pressure was exercised
        $display("Run done with %0d checks and %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #1;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d clock cycles, the DUT never finished", cycle_limit);
        $display("Something failed");
        $finish;
    end

endmodule : tb_mem_wr

// File: flist.f
+incdir+verilog
+incdir+dv
verilog/mem_wr_pkg.sv
verilog/mem_ctrl_pkg.sv
verilog/wr_cmd_queue.sv
verilog/mem_wr_controller.sv
verilog/mem_wr_peripheral.sv
verilog/mem_wr_top.sv
dv/tb_mem_wr.sv
